//--- all.f
+incdir+common
+incdir+test
common/exe_pkg.sv
common/mem_pkg.sv
exe/exe_alu.sv
exe/exe_mul.sv
lsu/lsu_xlate.sv
lsu/lsu_store_align.sv
source/exe_stage.sv
test/tb_exe_stage.sv

//--- common/exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// datapath and address width
`define EXE_XLEN 32

// general register index
`define EXE_REG_ADDR_W 5

// direct-map window segment, top bits of the address
`define EXE_SEG_W 3

// part of the address a window passes through untouched
`define EXE_SEG_OFF_W 29

`endif

//--- common/exe_pkg.sv
`include "exe_defines.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]       word_t;
    typedef logic [`EXE_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        mul_none, mul_w, mulh_w, mulh_wu
    } mul_op_e;

    typedef enum logic [3:0] {
        ls_none, ld_b, ld_bu, ld_h, ld_hu, ld_w, st_b, st_h, st_w
    } ls_op_e;

    // one instruction coming in from decode
    typedef struct packed {
        word_t     pc;
        word_t     imm;
        word_t     rj;
        word_t     rkd;
        reg_addr_t dest;
        logic      gr_we;
        logic      src1_is_pc;
        logic      src2_is_imm;
        alu_op_e   alu_op;
        mul_op_e   mul_op;
        ls_op_e    ls_op;
    } issue_t;

    // handed on to the memory stage
    typedef struct packed {
        word_t     pc;
        reg_addr_t dest;
        logic      gr_we;
        word_t     value;       // alu / mul result or vaddr
        ls_op_e    ls_op;
        logic [1:0] ld_off;
        logic      ale;
        logic      adem;
        logic      xlate_miss;
        logic      ex;
    } result_t;

endpackage

//--- common/mem_pkg.sv
`include "exe_defines.svh"

package mem_pkg;

    typedef logic [3:0] byte_en_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_e;

    typedef struct packed {
        logic [26:0] rsvd_hi;
        logic        pg;
        logic        da;
        logic        rsvd_lo;
        logic [1:0]  plv;
    } crmd_t;

    // direct-map window register
    typedef struct packed {
        logic [`EXE_SEG_W-1:0] vseg;    // 31:29
        logic                  rsvd_28;
        logic [`EXE_SEG_W-1:0] pseg;    // 27:25
        logic [20:0]           rsvd_mid;
        logic                  plv3_en;
        logic [1:0]            rsvd_lo;
        logic                  plv0_en;
    } dmw_t;

    typedef struct packed {
        logic           wr;
        size_e          size;
        byte_en_t       wstrb;
        exe_pkg::word_t addr;
        exe_pkg::word_t wdata;
    } mem_req_t;

endpackage

//--- exe/exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
    input  exe_pkg::alu_op_e alu_op,
    input  exe_pkg::word_t   src1,
    input  exe_pkg::word_t   src2,
    output exe_pkg::word_t   result
);
    import exe_pkg::*;

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src2[4:0];       // only low five bits matter

    always_comb begin
        case (alu_op)
            alu_add: begin
                result = sum;
            end
            alu_sub: begin
                result = diff;
            end
            alu_slt: begin
                result = word_t'($signed(src1) < $signed(src2));
            end
            alu_sltu: begin
                result = word_t'(src1 < src2);
            end
            alu_and: begin
                result = src1 & src2;
            end
            alu_or: begin
                result = src1 | src2;
            end
            alu_xor: begin
                result = src1 ^ src2;
            end
            alu_nor: begin
                result = ~(src1 | src2);
            end
            alu_sll: begin
                result = src1 << shamt;
            end
            alu_srl: begin
                result = src1 >> shamt;
            end
            alu_sra: begin
                result = word_t'($signed(src1) >>> shamt);
            end
            alu_lui: begin
                result = src2;      // imm already shifted by decode
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- exe/exe_mul.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_mul (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             clear,
    input  exe_pkg::mul_op_e mul_op,
    input  exe_pkg::word_t   src1,
    input  exe_pkg::word_t   src2,
    output exe_pkg::word_t   result,
    output logic             mul_done
);
    import exe_pkg::*;

    logic                        sign_ext;
    logic signed [`EXE_XLEN:0]   opa;
    logic signed [`EXE_XLEN:0]   opb;
    logic signed [2*`EXE_XLEN+1:0] prod;
    word_t                       prod_sel;

    // one 33x33 signed multiplier covers both signed and unsigned forms
    assign sign_ext = (mul_op != mulh_wu);
    assign opa      = {sign_ext & src1[`EXE_XLEN-1], src1};
    assign opb      = {sign_ext & src2[`EXE_XLEN-1], src2};
    assign prod     = opa * opb;

    assign prod_sel = (mul_op == mul_w) ? prod[`EXE_XLEN-1:0]
                                        : prod[2*`EXE_XLEN-1:`EXE_XLEN];

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_done <= 1'b0;
        end else if (clear) begin
            mul_done <= 1'b0;       // item left the stage
        end else if (start) begin
            mul_done <= 1'b1;
        end
    end

    // capture once, on the first cycle of the multiply
    always_ff @(posedge clk) begin
        if (start && !mul_done) begin
            result <= prod_sel;
        end
    end

endmodule

//--- lsu/lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align (
    input  exe_pkg::word_t    vaddr,
    input  exe_pkg::ls_op_e   ls_op,
    input  exe_pkg::word_t    rkd,
    output mem_pkg::size_e    size,
    output mem_pkg::byte_en_t wstrb,
    output exe_pkg::word_t    wdata,
    output logic              wr,
    output logic              ale
);
    import exe_pkg::*;
    import mem_pkg::*;

    logic       is_b;
    logic       is_h;
    logic       is_w;
    logic [1:0] off;
    byte_en_t   strb;

    assign is_b = ls_op inside {ld_b, ld_bu, st_b};
    assign is_h = ls_op inside {ld_h, ld_hu, st_h};
    assign is_w = ls_op inside {ld_w, st_w};
    assign wr   = ls_op inside {st_b, st_h, st_w};
    assign off  = vaddr[1:0];

    always_comb begin
        if (is_b) begin
            size  = size_byte;
            strb  = 4'b0001 << off;
            wdata = {4{rkd[7:0]}};      // byte lane picked by strobe
        end else if (is_h) begin
            size  = size_half;
            strb  = 4'b0011 << off;
            wdata = {2{rkd[15:0]}};
        end else begin
            size  = size_word;
            strb  = 4'b1111;
            wdata = rkd;
        end
    end

    assign wstrb = wr ? strb : '0;      // loads never write

    assign ale = (is_h && off[0]) || (is_w && (off != 2'b00));

endmodule

//--- lsu/lsu_xlate.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module lsu_xlate (
    input  exe_pkg::word_t vaddr,
    input  logic           mem_op,
    input  mem_pkg::crmd_t crmd,
    input  mem_pkg::dmw_t  dmw0,
    input  mem_pkg::dmw_t  dmw1,
    output exe_pkg::word_t paddr,
    output logic           adem,
    output logic           xlate_miss
);
    import exe_pkg::*;
    import mem_pkg::*;

    logic  mapped;
    logic  plv0;
    logic  plv3;
    logic  hit0;
    logic  hit1;
    word_t win0_addr;
    word_t win1_addr;

    // window matches on vseg and must be enabled for the current level
    function automatic logic win_hit(dmw_t w, word_t va, logic lvl0, logic lvl3);
        logic seg_eq;
        seg_eq  = (va[`EXE_XLEN-1 -: `EXE_SEG_W] == w.vseg);
        win_hit = seg_eq && ((lvl0 && w.plv0_en) || (lvl3 && w.plv3_en));
    endfunction

    assign mapped = ~crmd.da & crmd.pg;
    assign plv0   = (crmd.plv == 2'd0);
    assign plv3   = (crmd.plv == 2'd3);

    assign hit0 = mapped && win_hit(dmw0, vaddr, plv0, plv3);
    assign hit1 = mapped && win_hit(dmw1, vaddr, plv0, plv3);

    assign win0_addr = {dmw0.pseg, vaddr[`EXE_SEG_OFF_W-1:0]};
    assign win1_addr = {dmw1.pseg, vaddr[`EXE_SEG_OFF_W-1:0]};

    // dmw0 has priority; direct mode falls through to vaddr
    assign paddr = hit0 ? win0_addr :
                   hit1 ? win1_addr :
                          vaddr;

    // no tlb behind the windows
    assign xlate_miss = mem_op && mapped && !hit0 && !hit1;

    // user mode may not touch the upper half
    assign adem = mem_op && vaddr[`EXE_XLEN-1] && plv3;

endmodule

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_exe_stage -f all.f

# tee keeps the log even when the simulation stops on an error
./obj_dir/Vtb_exe_stage 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi

exit 0

//--- source/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_allowin,
    input  exe_pkg::issue_t   in_op,
    output logic              out_valid,
    input  logic              out_allowin,
    output exe_pkg::result_t  out_res,
    output logic              mem_req_valid,
    output mem_pkg::mem_req_t mem_req,
    input  mem_pkg::crmd_t    csr_crmd,
    input  mem_pkg::dmw_t     csr_dmw0,
    input  mem_pkg::dmw_t     csr_dmw1
);
    import exe_pkg::*;
    import mem_pkg::*;

    logic    valid;
    issue_t  op_r;
    logic    ready_go;
    logic    fire;
    logic    is_mul;
    logic    mem_op;
    alu_op_e alu_op_sel;
    word_t   src1;
    word_t   src2;
    word_t   alu_result;
    word_t   mul_result;
    logic    mul_done;
    word_t   paddr;
    logic    adem;
    logic    xlate_miss;
    logic    ale;
    logic    ex;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline register
    ////////////////////////////////////////////////////////////////////////////

    assign is_mul     = (op_r.mul_op != mul_none);
    assign mem_op     = (op_r.ls_op != ls_none);
    assign ready_go   = !is_mul || mul_done;    // mul waits one cycle
    assign in_allowin = !valid || (ready_go && out_allowin);
    assign out_valid  = valid && ready_go;
    assign fire       = out_valid && out_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_r <= in_op;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // operands and units
    ////////////////////////////////////////////////////////////////////////////

    assign src1 = op_r.src1_is_pc  ? op_r.pc  : op_r.rj;
    assign src2 = op_r.src2_is_imm ? op_r.imm : op_r.rkd;

    // address is always base + offset
    assign alu_op_sel = mem_op ? alu_add : op_r.alu_op;

    exe_alu u_alu (
        .alu_op (alu_op_sel),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    exe_mul u_mul (
        .clk      (clk),
        .reset    (reset),
        .start    (valid && is_mul),
        .clear    (fire),
        .mul_op   (op_r.mul_op),
        .src1     (src1),
        .src2     (src2),
        .result   (mul_result),
        .mul_done (mul_done)
    );

    lsu_xlate u_xlate (
        .vaddr      (alu_result),
        .mem_op     (mem_op),
        .crmd       (csr_crmd),
        .dmw0       (csr_dmw0),
        .dmw1       (csr_dmw1),
        .paddr      (paddr),
        .adem       (adem),
        .xlate_miss (xlate_miss)
    );

    lsu_store_align u_align (
        .vaddr (alu_result),
        .ls_op (op_r.ls_op),
        .rkd   (op_r.rkd),
        .size  (mem_req.size),
        .wstrb (mem_req.wstrb),
        .wdata (mem_req.wdata),
        .wr    (mem_req.wr),
        .ale   (ale)
    );

    ////////////////////////////////////////////////////////////////////////////
    // result and memory request
    ////////////////////////////////////////////////////////////////////////////

    assign ex = ale || adem || xlate_miss;

    always_comb begin
        out_res.pc         = op_r.pc;
        out_res.dest       = op_r.dest;
        out_res.gr_we      = op_r.gr_we;
        out_res.value      = is_mul ? mul_result : alu_result;
        out_res.ls_op      = op_r.ls_op;
        out_res.ld_off     = alu_result[1:0];  // byte select for the load path
        out_res.ale        = ale;
        out_res.adem       = adem;
        out_res.xlate_miss = xlate_miss;
        out_res.ex         = ex;
    end

    assign mem_req.addr  = paddr;
    assign mem_req_valid = fire && mem_op && !ex;   // memory takes it right away

endmodule

//--- test/tb_exe_model.svh
`ifndef TB_EXE_MODEL_SVH
`define TB_EXE_MODEL_SVH

// integer ops as listed for the stage, shift amount from src2[4:0]
function automatic word_t model_alu(input alu_op_e op, input word_t a, input word_t b);
    word_t r;
    case (op)
        alu_add:  r = a + b;
        alu_sub:  r = a + ~b + 32'd1;       // two's complement subtract
        alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
        alu_and:  r = a & b;
        alu_or:   r = a | b;
        alu_xor:  r = a ^ b;
        alu_nor:  r = ~(a | b);
        alu_sll:  r = a << b[4:0];
        alu_srl:  r = a >> b[4:0];
        alu_sra: begin
            r = a >> b[4:0];
            if (a[31]) begin
                r = r | ~(32'hffff_ffff >> b[4:0]);   // fill with sign
            end
        end
        alu_lui:  r = b;
        default:  r = 32'd0;
    endcase
    return r;
endfunction

function automatic word_t model_mul(input mul_op_e op, input word_t a, input word_t b);
    logic [63:0] p;
    if (op == mulh_wu) begin
        p = {32'd0, a} * {32'd0, b};
    end else begin
        p = {{32{a[31]}}, a} * {{32{b[31]}}, b};    // low 64 bits of signed product
    end
    return (op == mul_w) ? p[31:0] : p[63:32];
endfunction

// direct mode or the two windows, dmw0 first
function automatic void model_xlate(input word_t va, input logic mem, input crmd_t crmd,
                                    input dmw_t d0, input dmw_t d1, output word_t pa,
                                    output logic adem, output logic miss);
    logic mapped;
    logic en0;
    logic en1;
    mapped = (crmd.da == 1'b0) && (crmd.pg == 1'b1);
    en0    = (crmd.plv == 2'd0 && d0.plv0_en) || (crmd.plv == 2'd3 && d0.plv3_en);
    en1    = (crmd.plv == 2'd0 && d1.plv0_en) || (crmd.plv == 2'd3 && d1.plv3_en);
    pa     = va;
    miss   = 1'b0;
    if (mapped) begin
        if (en0 && va[31:29] == d0.vseg) begin
            pa = {d0.pseg, va[28:0]};
        end else if (en1 && va[31:29] == d1.vseg) begin
            pa = {d1.pseg, va[28:0]};
        end else begin
            miss = mem;
        end
    end
    adem = mem && va[31] && (crmd.plv == 2'd3);
endfunction

function automatic void model_align(input word_t va, input ls_op_e op, input word_t data,
                                    output size_e size, output byte_en_t strb,
                                    output word_t wdata, output logic wr, output logic ale);
    int         nb;
    int         i;
    logic [2:0] first;
    logic [2:0] nb3;
    case (op)
        ld_b, ld_bu, st_b: nb = 1;
        ld_h, ld_hu, st_h: nb = 2;
        default:           nb = 4;
    endcase
    size  = (nb == 1) ? size_byte : (nb == 2) ? size_half : size_word;
    wr    = (op == st_b) || (op == st_h) || (op == st_w);
    first = {1'b0, va[1:0]};
    nb3   = 3'(nb);
    strb  = 4'b0000;
    for (i = 0; i < 4; i++) begin
        wdata[8*i +: 8] = data[8*(i % nb) +: 8];     // lanes repeat every nb bytes
        if (wr && (nb == 4 || (3'(i) >= first && 3'(i) < first + nb3))) begin
            strb[i] = 1'b1;
        end
    end
    ale = (op != ls_none) && ((nb == 2 && va[0]) || (nb == 4 && va[1:0] != 2'b00));
endfunction

`endif

//--- test/tb_exe_stage.sv
`timescale 1ns/1ps

module tb_exe_stage;
    import exe_pkg::*;
    import mem_pkg::*;

    `include "tb_exe_model.svh"

    localparam int N_ITEMS    = 400;
    localparam int BLOCK      = 50;
    localparam int MAX_CYCLES = N_ITEMS * 8 + 200;

    logic     clk;
    logic     reset;
    logic     in_valid;
    logic     in_allowin;
    issue_t   in_op;
    logic     out_valid;
    logic     out_allowin;
    result_t  out_res;
    logic     mem_req_valid;
    mem_req_t mem_req;
    crmd_t    csr_crmd;
    dmw_t     csr_dmw0;
    dmw_t     csr_dmw1;

    int       seed;
    int       cycle_count;
    int       n_sent;
    int       n_done;
    int       cfg_block;
    int       age;                      // cycles the item has spent in the stage
    logic     taken;                    // in_op accepted at the last edge
    logic     held;
    result_t  held_res;
    issue_t   q[$];                     // accepted, not yet out

    exe_stage i_dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_allowin    (in_allowin),
        .in_op         (in_op),
        .out_valid     (out_valid),
        .out_allowin   (out_allowin),
        .out_res       (out_res),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .csr_crmd      (csr_crmd),
        .csr_dmw0      (csr_dmw0),
        .csr_dmw1      (csr_dmw1)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            stop_with_error($sformatf("run timed out after %0d cycles, %0d of %0d items out",
                                      cycle_count, n_done, N_ITEMS));
        end
    end

    task automatic stop_with_error(input string msg);
        $display("Error: %s", msg);
        $display("tests failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_value(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic configure_csr();
        logic [31:0] r;
        r            = rand_word();
        csr_crmd     = '0;
        csr_crmd.plv = r[0] ? 2'd3 : 2'd0;
        csr_crmd.da  = !r[1];               // direct mode
        csr_crmd.pg  = r[1];                // mapped mode
        csr_dmw0     = dmw_t'(rand_word());
        csr_dmw1     = dmw_t'(rand_word());
    endtask

    task automatic make_item(output issue_t it);
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] w;
        r              = rand_word();
        r2             = rand_word();
        w              = rand_word();
        it.pc          = {w[31:2], 2'b00};
        it.imm         = rand_word();
        it.rj          = rand_word();
        it.rkd         = rand_word();
        it.dest        = r[6:2];
        it.gr_we       = r[7];
        it.src1_is_pc  = r[8];
        it.src2_is_imm = r[9];
        it.alu_op      = alu_op_e'(4'(r[31:16] % 16'd12));
        it.mul_op      = mul_none;
        it.ls_op       = ls_none;
        if (r[1:0] == 2'd1) begin
            it.mul_op = mul_op_e'(2'(r[15:12] % 4'd3) + 2'd1);
        end else if (r[1]) begin
            it.ls_op       = ls_op_e'(4'(r2[31:16] % 16'd8) + 4'd1);
            it.src1_is_pc  = 1'b0;          // base register plus offset
            it.src2_is_imm = 1'b1;
            it.imm         = {{20{w[11]}}, w[11:0]};
            if (r2[0]) begin
                it.rj[31:29] = r2[1] ? csr_dmw1.vseg : csr_dmw0.vseg;   // aim at a window
            end
            if (r2[2]) begin
                it.rj[1:0]  = 2'b00;
                it.imm[1:0] = 2'b00;
            end
        end
    endtask

    task automatic drive_inputs();
        issue_t it;
        int     block;
        if (taken) begin
            in_valid = 1'b0;
            taken    = 1'b0;
        end
        block = n_sent / BLOCK;
        if (!in_valid && n_sent < N_ITEMS) begin
            if (block != cfg_block) begin
                if (q.size() == 0) begin    // new csr view only on an empty stage
                    configure_csr();
                    cfg_block = block;
                end
            end else if (rand_word() % 32'd4 != 32'd0) begin
                make_item(it);
                in_op    = it;
                in_valid = 1'b1;
            end
        end
        out_allowin = (rand_word() % 32'd3) != 32'd0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // expected values and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic expect_item(input issue_t it, output result_t res, output mem_req_t req,
                               output logic req_valid, output string tname);
        word_t    s1;
        word_t    s2;
        word_t    alu_val;
        logic     mem;
        logic     ale;
        logic     adem;
        logic     miss;
        s1      = it.src1_is_pc ? it.pc : it.rj;
        s2      = it.src2_is_imm ? it.imm : it.rkd;
        mem     = (it.ls_op != ls_none);
        alu_val = model_alu(mem ? alu_add : it.alu_op, s1, s2);   // vaddr for memory ops
        model_xlate(alu_val, mem, csr_crmd, csr_dmw0, csr_dmw1, req.addr, adem, miss);
        model_align(alu_val, it.ls_op, it.rkd, req.size, req.wstrb, req.wdata, req.wr, ale);
        res.pc         = it.pc;
        res.dest       = it.dest;
        res.gr_we      = it.gr_we;
        res.value      = (it.mul_op != mul_none) ? model_mul(it.mul_op, s1, s2) : alu_val;
        res.ls_op      = it.ls_op;
        res.ld_off     = alu_val[1:0];
        res.ale        = ale;
        res.adem       = adem;
        res.xlate_miss = miss;
        res.ex         = ale || adem || miss;
        req_valid      = mem && !res.ex;
        tname          = mem ? "mem" : (it.mul_op != mul_none) ? "mul" : "alu";
    endtask

    task automatic observe();
        issue_t   it;
        result_t  exp_res;
        mem_req_t exp_req;
        logic     exp_req_valid;
        logic     exp_valid;
        logic     exp_allowin;
        string    tname;
        // one cycle to the output, two for a multiply
        if (q.size() != 0) begin
            age++;
            it        = q[0];
            exp_valid = age >= ((it.mul_op != mul_none) ? 2 : 1);
        end else begin
            exp_valid = 1'b0;
        end
        exp_allowin = (q.size() == 0) || (exp_valid && out_allowin);
        check_value("out_valid", 96'(exp_valid), 96'(out_valid));
        check_value("in_allowin", 96'(exp_allowin), 96'(in_allowin));
        if (held) begin
            check_value("held result", 96'(held_res), 96'(out_res));
        end
        if (out_valid && out_allowin) begin
            if (q.size() == 0) begin
                stop_with_error("an item left the stage that was never accepted");
            end else begin
                it = q.pop_front();
                expect_item(it, exp_res, exp_req, exp_req_valid, tname);
                check_value({tname, " value"}, 96'(exp_res.value), 96'(out_res.value));
                check_value({tname, " result"}, 96'(exp_res), 96'(out_res));
                check_value({tname, " req_valid"}, 96'(exp_req_valid), 96'(mem_req_valid));
                if (exp_req_valid) begin
                    check_value({tname, " request"}, 96'(exp_req), 96'(mem_req));
                end
                n_done++;
            end
        end else begin
            check_value("idle req_valid", 96'(1'b0), 96'(mem_req_valid));
        end
        held     = out_valid && !out_allowin;
        held_res = out_res;
        if (in_valid && in_allowin) begin
            q.push_back(in_op);
            n_sent++;
            age   = 0;
            taken = 1'b1;
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        drive_inputs();
        #1;                             // inputs and comb outputs settled
        observe();
    endtask

    initial begin
        seed        = 32'hb4f9_cca2;
        cycle_count = 0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_op       = '0;
        out_allowin = 1'b0;
        csr_crmd    = '0;
        csr_dmw0    = '0;
        csr_dmw1    = '0;
        n_sent      = 0;
        n_done      = 0;
        cfg_block   = -1;
        age         = 0;
        taken       = 1'b0;
        held        = 1'b0;
        held_res    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (n_done < N_ITEMS) begin
            run_cycle();
        end
        // stage must stay empty once the last item is out
        repeat (4) begin
            run_cycle();
        end
        $display("all tests passed");
        $finish;
    end

endmodule
